//--- wresp_bank.f
+incdir+tests
hdl/wresp_bank_pkg.sv
hdl/slot_allocator.sv
hdl/id_queue.sv
hdl/link_store.sv
hdl/release_arbiter.sv
hdl/wresp_bank.sv
tests/wresp_bank_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the wresp_bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f wresp_bank.f \
  --top-module wresp_bank_tb -o wresp_bank_sim
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

out=$(./obj_dir/wresp_bank_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "Pass message not found"
exit 1

//--- tests/wresp_bank_stim.svh
////////////////////
// Stimulus tasks and reference model of the write-response bank testbench
// Included inside the testbench module
////////////////////

`ifndef WRESP_BANK_STIM_SVH
`define WRESP_BANK_STIM_SVH

// Reserved addresses per identifier in reservation order
int unsigned res_q [NumIds][$];
int nfill [NumIds];
logic [Capacity-1:0] used_model;
wresp_bank_pkg::msg_t exp_msg [Capacity];
int out_ids [$];
logic [15:0] lfsr_q = 16'd95;

// Fibonacci LFSR with taps 16 14 13 11
// One step per bit taken
function automatic int rand_bits(input int n);
  int r;
  logic fb;
  r = 0;
  for (int i = 0; i < n; i++) begin
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    r = (r << 1) | int'(fb);
  end
  return r;
endfunction

function automatic int lowest_free();
  for (int i = 0; i < Capacity; i++) begin
    if (!used_model[i]) return i;
  end
  return -1;
endfunction

function automatic int outstanding();
  int n;
  n = 0;
  for (int id = 0; id < NumIds; id++) n += res_q[id].size();
  return n;
endfunction

task automatic reserve(input int id);
  int exp_addr;
  @(posedge clk_i);
  res_id_i <= wresp_bank_pkg::id_t'(id);
  res_ready_i <= 1'b1;
  // Slots freed at this edge are already clear in the model
  exp_addr = lowest_free();
  @(negedge clk_i);
  assert (res_valid_o) else stop_with_error("no free slot offered for a reservation");
  assert (int'(res_addr_o) == exp_addr)
    else wrong_value("res_addr", exp_addr, int'(res_addr_o));
  res_q[id].push_back(exp_addr);
  used_model[exp_addr] = 1'b1;
  @(posedge clk_i);
  res_ready_i <= 1'b0;
endtask

task automatic fill(input int id, input int payload);
  wresp_bank_pkg::msg_t m;
  int addr;
  m.id = wresp_bank_pkg::id_t'(id);
  m.payload = wresp_bank_pkg::payload_t'(payload);
  @(posedge clk_i);
  in_msg_i <= m;
  in_valid_i <= 1'b1;
  @(negedge clk_i);
  assert (in_ready_o) else stop_with_error("input refused although a reservation is open");
  addr = res_q[id][nfill[id]];
  exp_msg[addr] = m;
  nfill[id]++;
  @(posedge clk_i);
  in_valid_i <= 1'b0;
endtask

task automatic probe_ready(input int id);
  wresp_bank_pkg::msg_t m;
  logic expected;
  m = '0;
  m.id = wresp_bank_pkg::id_t'(id);
  @(posedge clk_i);
  in_msg_i <= m;
  in_valid_i <= 1'b0;
  @(negedge clk_i);
  expected = nfill[id] < res_q[id].size();
  assert (in_ready_o == expected)
    else wrong_value("in_ready", int'(expected), int'(in_ready_o));
endtask

task automatic fill_all();
  for (int id = 0; id < NumIds; id++) begin
    while (nfill[id] < res_q[id].size()) fill(id, rand_bits(16));
  end
endtask

task automatic wait_drain();
  @(posedge clk_i);
  while (outstanding() != 0) @(posedge clk_i);
endtask

`endif

//--- tests/wresp_bank_tb.sv
////////////////////
// Testbench of the write-response bank
// Runs six directed and random tests against a reference model
////////////////////

module wresp_bank_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int Capacity = wresp_bank_pkg::DefaultCapacity;
  localparam int AddrWidth = $clog2(Capacity);
  localparam int NumIds = wresp_bank_pkg::NumIds;
  // Six tests of at most about 300 cycles each plus margin
  localparam int MaxCycles = 2000;

  logic clk_i;
  logic rst_ni;
  wresp_bank_pkg::id_t res_id_i;
  logic res_ready_i;
  logic res_valid_o;
  logic [AddrWidth-1:0] res_addr_o;
  wresp_bank_pkg::msg_t in_msg_i;
  logic in_valid_i;
  logic in_ready_o;
  logic [Capacity-1:0] release_en_i;
  wresp_bank_pkg::msg_t out_msg_o;
  logic out_valid_o;
  logic out_ready_i;
  logic [Capacity-1:0] released_o;
  string test_name = "reset";
  int cycles = 0;
  logic rand_ready = 1'b0;
  logic ready_draw = 1'b1;

  task automatic wrong_value(input string what, input int exp, input int act);
    $display("MISMATCH %s: %s expected %0h actual %0h", test_name, what, exp, act);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic stop_with_error(input string what);
    $display("ERROR in %s: %s", test_name, what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  `include "wresp_bank_stim.svh"

  wresp_bank #(.Capacity(Capacity)) i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) stop_with_error("timeout, the run exceeded its cycle limit");
    if (rand_ready) out_ready_i <= ready_draw;
  end

  // Random ready drawn between rising edges
  always @(negedge clk_i) begin
    if (rand_ready) ready_draw = rand_bits(2) != 0;
  end

  // Output checker
  // A transfer seen here completes at the next rising edge
  always @(negedge clk_i) begin
    int id;
    int head;
    if (rst_ni && out_valid_o && out_ready_i) begin
      id = int'(out_msg_o.id);
      if (nfill[id] == 0) stop_with_error("output without a filled reservation");
      head = res_q[id][0];
      assert (released_o == Capacity'(1) << head)
        else wrong_value("released", 1 << head, int'(released_o));
      assert (out_msg_o == exp_msg[head])
        else wrong_value("out_msg", int'(exp_msg[head]), int'(out_msg_o));
      void'(res_q[id].pop_front());
      nfill[id]--;
      used_model[head] = 1'b0;
      out_ids.push_back(id);
    end
  end

  ////////////////////
  // Protocol checks
  ////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      released_o == '0 || (out_valid_o && out_ready_i))
    else stop_with_error("released_o set without a transfer");

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(released_o))
    else stop_with_error("released_o has more than one bit set");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_msg_o)))
    else stop_with_error("output changed while stalled");

  initial begin
    int wait_cycles;
    wresp_bank_pkg::msg_t held;
    logic [Capacity-1:0] release_mask;
    rst_ni = 1'b0;
    res_id_i = '0;
    res_ready_i = 1'b0;
    in_msg_i = '0;
    in_valid_i = 1'b0;
    release_en_i = '1;
    out_ready_i = 1'b1;
    used_model = '0;
    for (int i = 0; i < NumIds; i++) nfill[i] = 0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o && released_o == '0)
      else stop_with_error("output active after reset");
    assert (res_valid_o && !in_ready_o)
      else stop_with_error("wrong handshake state after reset");
    for (int i = 0; i < 6; i++) reserve(i % NumIds);
    fill_all();
    wait_drain();

    test_name = "order";
    release_en_i <= '0;
    for (int id = NumIds - 1; id >= 0; id--) reserve(id);
    fill_all();
    out_ids.delete();
    release_en_i <= '1;
    wait_drain();
    for (int i = 0; i < NumIds; i++) begin
      assert (out_ids[i] == i) else wrong_value("id order", i, out_ids[i]);
    end
    rand_ready <= 1'b1;
    repeat (10) begin
      reserve(rand_bits(2));
      if (rand_bits(1) != 0) fill_all();
    end
    fill_all();
    wait_drain();
    rand_ready <= 1'b0;
    @(posedge clk_i);
    out_ready_i <= 1'b1;

    test_name = "gating";
    release_en_i <= '0;
    reserve(1);
    fill(1, rand_bits(16));
    repeat (5) begin
      @(negedge clk_i);
      assert (!out_valid_o)
        else stop_with_error("output presented without release enable");
    end
    @(posedge clk_i);
    release_en_i <= Capacity'(1) << res_q[1][0];
    wait_cycles = 0;
    @(negedge clk_i);
    while (!out_valid_o) begin
      wait_cycles++;
      @(negedge clk_i);
    end
    assert (wait_cycles == 1) else wrong_value("release latency", 1, wait_cycles);
    wait_drain();

    test_name = "acceptance";
    release_en_i <= '1;
    reserve(2);
    for (int id = 0; id < NumIds; id++) probe_ready(id);
    fill(2, rand_bits(16));
    probe_ready(2);
    wait_drain();

    test_name = "full";
    release_en_i <= '0;
    for (int i = 0; i < Capacity; i++) reserve(i % NumIds);
    @(negedge clk_i);
    assert (!res_valid_o) else stop_with_error("free slot offered in a full bank");
    fill_all();
    release_mask = '0;
    for (int i = 0; i < res_q[3].size(); i++) release_mask[res_q[3][i]] = 1'b1;
    @(posedge clk_i);
    release_en_i <= release_mask;
    while (res_q[3].size() != 0) @(posedge clk_i);
    reserve(0);
    fill_all();
    release_en_i <= '1;
    wait_drain();

    test_name = "backpressure";
    out_ready_i <= 1'b0;
    reserve(2);
    fill(2, rand_bits(16));
    @(negedge clk_i);
    while (!out_valid_o) @(negedge clk_i);
    held = out_msg_o;
    @(posedge clk_i);
    release_en_i <= '0;
    repeat (4) begin
      @(negedge clk_i);
      assert (out_valid_o && out_msg_o == held)
        else wrong_value("stalled out_msg", int'(held), int'(out_msg_o));
    end
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    wait_drain();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- hdl/wresp_bank.sv
////////////////////
// Write-response bank of the simulated memory controller
// Slots are reserved per identifier, filled in order and released under enable
////////////////////

module wresp_bank #(
  parameter int Capacity = wresp_bank_pkg::DefaultCapacity,
  localparam int AddrWidth = $clog2(Capacity)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Reservation
  input  wresp_bank_pkg::id_t   res_id_i,
  input  logic                  res_ready_i,
  output logic                  res_valid_o,
  output logic [AddrWidth-1:0]  res_addr_o,
  // Input responses
  input  wresp_bank_pkg::msg_t  in_msg_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  // Output responses
  input  logic [Capacity-1:0]   release_en_i,
  output wresp_bank_pkg::msg_t  out_msg_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [Capacity-1:0]   released_o
);

  localparam int NumIds = wresp_bank_pkg::NumIds;

  typedef logic [AddrWidth-1:0] addr_t;

  logic res_fire;
  logic in_fire;
  logic free;
  addr_t next_addr;
  addr_t held_addr;
  addr_t fill_next;
  addr_t oldest_next;

  // Per-queue status
  logic [NumIds-1:0] q_can_fill;
  logic [NumIds-1:0] q_has_filled;
  logic [NumIds-1:0] q_has_any;
  logic [NumIds-1:0] q_pop;
  logic [NumIds-1:0][AddrWidth-1:0] q_fill_slot;
  logic [NumIds-1:0][AddrWidth-1:0] q_oldest_slot;
  logic [NumIds-1:0][AddrWidth-1:0] q_newest_slot;

  assign res_fire = res_valid_o && res_ready_i;
  assign in_fire = in_valid_i && in_ready_o;
  assign res_addr_o = next_addr;

  // Ready depends on the identifier of the offered message
  assign in_ready_o = q_can_fill[in_msg_i.id];

  slot_allocator #(
    .Capacity(Capacity)
  ) i_slot_allocator (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .alloc_i    (res_fire),
    .free_i     (free),
    .free_addr_i(held_addr),
    .next_addr_o(next_addr),
    .has_free_o (res_valid_o)
  );

  for (genvar i = 0; i < NumIds; i++) begin : gen_queues
    id_queue #(
      .Capacity(Capacity)
    ) i_id_queue (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .reserve_i    (res_fire && res_id_i == wresp_bank_pkg::id_t'(i)),
      .slot_i       (next_addr),
      .fill_i       (in_fire && in_msg_i.id == wresp_bank_pkg::id_t'(i)),
      .pop_i        (q_pop[i]),
      .fill_next_i  (fill_next),
      .oldest_next_i(oldest_next),
      .fill_slot_o  (q_fill_slot[i]),
      .can_fill_o   (q_can_fill[i]),
      .oldest_slot_o(q_oldest_slot[i]),
      .has_filled_o (q_has_filled[i]),
      .newest_slot_o(q_newest_slot[i]),
      .has_any_o    (q_has_any[i])
    );
  end

  // A new reservation is linked behind the newest slot of its identifier.
  // The popped slot is always the held address, so its successor is read there
  link_store #(
    .Capacity(Capacity)
  ) i_link_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .link_we_i     (res_fire && q_has_any[res_id_i]),
    .link_addr_i   (q_newest_slot[res_id_i]),
    .link_data_i   (next_addr),
    .msg_we_i      (in_fire),
    .msg_addr_i    (q_fill_slot[in_msg_i.id]),
    .msg_i         (in_msg_i),
    .next_raddr_a_i(q_fill_slot[in_msg_i.id]),
    .next_raddr_b_i(held_addr),
    .next_a_o      (fill_next),
    .next_b_o      (oldest_next),
    .msg_raddr_i   (held_addr),
    .msg_o         (out_msg_o)
  );

  release_arbiter #(
    .Capacity(Capacity)
  ) i_release_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cand_valid_i(q_has_filled),
    .cand_addr_i (q_oldest_slot),
    .release_en_i(release_en_i),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .held_addr_o (held_addr),
    .pop_o       (q_pop),
    .free_o      (free),
    .released_o  (released_o)
  );

endmodule

//--- hdl/release_arbiter.sv
////////////////////
// Output stage of the bank
// Picks the lowest releasable identifier and holds its slot until accepted
////////////////////

module release_arbiter #(
  parameter int Capacity = wresp_bank_pkg::DefaultCapacity,
  localparam int AddrWidth = $clog2(Capacity)
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [wresp_bank_pkg::NumIds-1:0]                cand_valid_i,
  input  logic [wresp_bank_pkg::NumIds-1:0][AddrWidth-1:0] cand_addr_i,
  input  logic [Capacity-1:0]                           release_en_i,
  input  logic                                          out_ready_i,
  output logic                                          out_valid_o,
  output logic [AddrWidth-1:0]                          held_addr_o,
  output logic [wresp_bank_pkg::NumIds-1:0]                pop_o,
  output logic                                          free_o,
  output logic [Capacity-1:0]                           released_o
);

  localparam int NumIds = wresp_bank_pkg::NumIds;

  typedef logic [AddrWidth-1:0] addr_t;

  wresp_bank_pkg::out_state_e state_q;
  wresp_bank_pkg::id_t held_id_q;
  wresp_bank_pkg::id_t pick_id;
  addr_t held_addr_q;
  logic [NumIds-1:0] cand_ok;
  logic transfer;
  logic may_select;

  assign out_valid_o = state_q == wresp_bank_pkg::OUT_PRESENT;
  assign transfer = out_valid_o && out_ready_i;
  assign may_select = !out_valid_o || out_ready_i;

  // The presented queue still shows the held slot as its oldest until the pop
  always_comb begin
    pick_id = '0;
    for (int i = 0; i < NumIds; i++) begin
      cand_ok[i] = cand_valid_i[i] && release_en_i[cand_addr_i[i]] &&
          !(out_valid_o && held_id_q == wresp_bank_pkg::id_t'(i));
    end
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (cand_ok[i]) begin
        pick_id = wresp_bank_pkg::id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= wresp_bank_pkg::OUT_IDLE;
      held_id_q <= '0;
      held_addr_q <= '0;
    end else if (may_select) begin
      if (|cand_ok) begin
        state_q <= wresp_bank_pkg::OUT_PRESENT;
        held_id_q <= pick_id;
        held_addr_q <= cand_addr_i[pick_id];
      end else begin
        state_q <= wresp_bank_pkg::OUT_IDLE;
      end
    end
  end

  // Transfer side effects
  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      pop_o[i] = transfer && held_id_q == wresp_bank_pkg::id_t'(i);
    end
    for (int a = 0; a < Capacity; a++) begin
      released_o[a] = transfer && held_addr_q == addr_t'(a);
    end
  end

  assign free_o = transfer;
  assign held_addr_o = held_addr_q;

endmodule

//--- hdl/link_store.sv
////////////////////
// Register file of stored responses and next-slot pointers
// Writes land at the clock edge, all reads are combinational
////////////////////

module link_store #(
  parameter int Capacity = wresp_bank_pkg::DefaultCapacity,
  localparam int AddrWidth = $clog2(Capacity)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Pointer write port
  input  logic                 link_we_i,
  input  logic [AddrWidth-1:0] link_addr_i,
  input  logic [AddrWidth-1:0] link_data_i,
  // Message write port
  input  logic                 msg_we_i,
  input  logic [AddrWidth-1:0] msg_addr_i,
  input  wresp_bank_pkg::msg_t msg_i,
  // Pointer read ports
  input  logic [AddrWidth-1:0] next_raddr_a_i,
  input  logic [AddrWidth-1:0] next_raddr_b_i,
  output logic [AddrWidth-1:0] next_a_o,
  output logic [AddrWidth-1:0] next_b_o,
  // Message read port
  input  logic [AddrWidth-1:0] msg_raddr_i,
  output wresp_bank_pkg::msg_t msg_o
);

  typedef logic [AddrWidth-1:0] addr_t;

  addr_t next_q [Capacity];
  wresp_bank_pkg::msg_t msg_q [Capacity];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      next_q <= '{default: '0};
    end else if (link_we_i) begin
      next_q[link_addr_i] <= link_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (msg_we_i) begin
      msg_q[msg_addr_i] <= msg_i;
    end
  end

  assign next_a_o = next_q[next_raddr_a_i];
  assign next_b_o = next_q[next_raddr_b_i];
  assign msg_o = msg_q[msg_raddr_i];

endmodule

//--- hdl/id_queue.sv
////////////////////
// Pointers and counts of one identifier's linked list
// Filled slots sit ahead of reserved ones, from oldest to newest
////////////////////

module id_queue #(
  parameter int Capacity = wresp_bank_pkg::DefaultCapacity,
  localparam int AddrWidth = $clog2(Capacity)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 reserve_i,
  input  logic [AddrWidth-1:0] slot_i,
  input  logic                 fill_i,
  input  logic                 pop_i,
  // Successors of the fill and oldest slots
  input  logic [AddrWidth-1:0] fill_next_i,
  input  logic [AddrWidth-1:0] oldest_next_i,
  output logic [AddrWidth-1:0] fill_slot_o,
  output logic                 can_fill_o,
  output logic [AddrWidth-1:0] oldest_slot_o,
  output logic                 has_filled_o,
  output logic [AddrWidth-1:0] newest_slot_o,
  output logic                 has_any_o
);

  localparam int CntWidth = $clog2(Capacity + 1);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  addr_t newest_q;
  addr_t newest_d;
  addr_t fill_q;
  addr_t fill_d;
  addr_t oldest_q;
  addr_t oldest_d;
  cnt_t unfilled_q;
  cnt_t unfilled_d;
  cnt_t filled_q;
  cnt_t filled_d;

  // Entries of each part still present after this cycle's fill and pop
  cnt_t unfilled_left;
  cnt_t filled_left;

  always_comb begin
    unfilled_left = unfilled_q - cnt_t'(fill_i);
    filled_left = filled_q - cnt_t'(pop_i);
    unfilled_d = unfilled_left + cnt_t'(reserve_i);
    filled_d = filled_left + cnt_t'(fill_i);

    newest_d = reserve_i ? slot_i : newest_q;

    // Fill pointer walks the list, restarts at a new reservation when drained
    fill_d = fill_i ? fill_next_i : fill_q;
    if (unfilled_left == '0 && reserve_i) begin
      fill_d = slot_i;
    end

    // With no filled entry left the head is the first unfilled slot,
    // or the slot reserved right now on an empty list
    oldest_d = pop_i ? oldest_next_i : oldest_q;
    if (filled_left == '0) begin
      oldest_d = (unfilled_q != '0) ? fill_q : slot_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      newest_q <= '0;
      fill_q <= '0;
      oldest_q <= '0;
      unfilled_q <= '0;
      filled_q <= '0;
    end else begin
      newest_q <= newest_d;
      fill_q <= fill_d;
      oldest_q <= oldest_d;
      unfilled_q <= unfilled_d;
      filled_q <= filled_d;
    end
  end

  assign fill_slot_o = fill_q;
  assign can_fill_o = unfilled_q != '0;
  assign oldest_slot_o = oldest_q;
  assign has_filled_o = filled_q != '0;
  assign newest_slot_o = newest_q;
  assign has_any_o = (unfilled_q != '0) || (filled_q != '0);

endmodule

//--- hdl/slot_allocator.sv
////////////////////
// Slot occupancy of the bank
// Offers the lowest free address and tracks reserve and free events
////////////////////

module slot_allocator #(
  parameter int Capacity = wresp_bank_pkg::DefaultCapacity,
  localparam int AddrWidth = $clog2(Capacity)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 alloc_i,
  input  logic                 free_i,
  input  logic [AddrWidth-1:0] free_addr_i,
  output logic [AddrWidth-1:0] next_addr_o,
  output logic                 has_free_o
);

  logic [Capacity-1:0] used_q;
  logic [Capacity-1:0] used_d;

  ////////////////////
  // Lowest free slot
  ////////////////////

  // Scan from the top so the lowest clear bit wins
  always_comb begin
    next_addr_o = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        next_addr_o = AddrWidth'(i);
      end
    end
  end

  assign has_free_o = ~&used_q;

  ////////////////////
  // Used bits
  ////////////////////

  // Reserved and freed slots never coincide,
  // a slot being freed is still marked used during that cycle
  always_comb begin
    used_d = used_q;
    if (alloc_i) begin
      used_d[next_addr_o] = 1'b1;
    end
    if (free_i) begin
      used_d[free_addr_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

endmodule

//--- hdl/wresp_bank_pkg.sv
////////////////////
// Shared widths and types of the write-response bank
// Modules refer to these by scoped name, the message struct fixes the widths
////////////////////

package wresp_bank_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // AXI-style identifier width
  localparam int IdWidth = 2;

  // One linked list per identifier
  localparam int NumIds = 2 ** IdWidth;

  // Response payload bits carried next to the identifier
  localparam int PayloadWidth = 16;

  // Slot count used by the top level unless overridden
  localparam int DefaultCapacity = 16;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [IdWidth-1:0] id_t;

  typedef logic [PayloadWidth-1:0] payload_t;

  // Stored response, the identifier travels with the payload
  typedef struct packed {
    id_t      id;
    payload_t payload;
  } msg_t;

  // Release arbiter output stage
  typedef enum logic {
    OUT_IDLE    = 1'b0,
    OUT_PRESENT = 1'b1
  } out_state_e;

endpackage
